//--- src/cache_geom_pkg.sv
/*
 * L1 cache geometry
 * sizes shared by both caches and the address view used for
 * tag compare, bank select, refill and write-back addressing
 */
package cache_geom_pkg;

    localparam int ADDR_W     = 64;
    localparam int LINE_W     = 128;  // one line is 16 bytes
    localparam int WORD_W     = 64;
    localparam int NLINE      = 256;
    localparam int NBANK      = 4;
    localparam int BANK_DEPTH = 64;
    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 8;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

    // index split, upper bits pick the bank
    localparam int BANK_W  = $clog2(NBANK);
    localparam int LINE_AW = $clog2(BANK_DEPTH);

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_fields_t;

    // same 64-bit word, seen as a plain address or split into fields
    typedef union packed {
        logic [ADDR_W-1:0]  raw;
        cache_addr_fields_t f;
    } cache_addr_u;

endpackage

//--- src/cache_bus_pkg.sv
/*
 * L1 cache bus types
 * CPU request/response and the shared main-memory request/response
 */
package cache_bus_pkg;
    import cache_geom_pkg::*;

    typedef struct packed {
        logic                valid;   // held until ready
        logic                rw;      // 1 = write
        logic [ADDR_W-1:0]   addr;
        logic [WORD_W-1:0]   wdata;
        logic [WORD_W/8-1:0] wmask;
    } cpu_req_t;

    typedef struct packed {
        logic              ready;     // one-cycle pulse
        logic [WORD_W-1:0] rdata;
    } cpu_rsp_t;

    // line transfer to main memory
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;      // line aligned
        logic [LINE_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              ready;
        logic [LINE_W-1:0] rdata;     // read line, valid with ready
    } mem_rsp_t;

endpackage

//--- src/line_sram.sv
/*
 * line bank
 * 64 lines of 128 bits, one-cycle synchronous read, write on we_i
 */
`timescale 1ns/1ps

module line_sram
    import cache_geom_pkg::*;
(
    input  logic               clk,
    input  logic               we_i,
    input  logic [LINE_AW-1:0] addr_i,
    input  logic [LINE_W-1:0]  wdata_i,
    output logic [LINE_W-1:0]  rdata_o
);

    logic [LINE_W-1:0] mem [BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end else begin
            rdata_o <= mem[addr_i];  // output holds during a write
        end
    end

endmodule

//--- src/icache.sv
/*
 * instruction cache
 * direct mapped, read only, 256 lines in four banks,
 * refills a line from memory on a miss
 */
`timescale 1ns/1ps

module icache
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t req_i,
    output cpu_rsp_t rsp_o,
    output mem_req_t mem_req_o,
    input  mem_rsp_t mem_rsp_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_COMPARE,
        S_ALLOC,
        S_READ_OUT
    } state_e;

    state_e             state_q, state_d;
    cache_addr_u        req_addr, fill_addr;
    logic [INDEX_W-1:0] idx;
    logic [BANK_W-1:0]  bank_sel;
    logic [NLINE-1:0]   valid_q;
    logic [TAG_W-1:0]   tag_q [NLINE];
    logic               hit;
    logic               refill_done;
    logic [LINE_W-1:0]  bank_rd [NBANK];
    logic [LINE_W-1:0]  line_rd;
    logic               ready_q;
    logic [WORD_W-1:0]  rdata_q;

    assign req_addr.raw = req_i.addr;
    assign idx          = req_addr.f.index;
    assign bank_sel     = idx[INDEX_W-1 -: BANK_W];

    always_comb begin
        fill_addr          = req_addr;
        fill_addr.f.offset = '0;
    end

    assign hit         = valid_q[idx] && (tag_q[idx] == req_addr.f.tag);
    assign refill_done = (state_q == S_ALLOC) && mem_rsp_i.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:     if (req_i.valid) state_d = S_COMPARE;
            S_COMPARE:  state_d = hit ? S_READ_OUT : S_ALLOC;
            S_ALLOC:    if (mem_rsp_i.ready) state_d = S_COMPARE;  // compare again
            S_READ_OUT: state_d = S_IDLE;
            default:    state_d = S_IDLE;
        endcase
    end

    for (genvar b = 0; b < NBANK; b++) begin : g_bank
        line_sram i_bank (
            .clk     (clk),
            .we_i    (refill_done && (bank_sel == BANK_W'(b))),
            .addr_i  (idx[LINE_AW-1:0]),
            .wdata_i (mem_rsp_i.rdata),
            .rdata_o (bank_rd[b])
        );
    end

    assign line_rd = bank_rd[bank_sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (refill_done) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_q[idx] <= req_addr.f.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= (state_q == S_READ_OUT);
        end
    end

    // offset bit 3 picks the half
    always_ff @(posedge clk) begin
        if (state_q == S_READ_OUT) begin
            rdata_q <= line_rd[req_addr.f.offset[OFFSET_W-1]*WORD_W +: WORD_W];
        end
    end

    assign rsp_o.ready = ready_q;
    assign rsp_o.rdata = rdata_q;

    assign mem_req_o.valid = (state_q == S_ALLOC);
    assign mem_req_o.write = 1'b0;
    assign mem_req_o.addr  = fill_addr.raw;
    assign mem_req_o.wdata = '0;

endmodule

//--- src/dcache.sv
/*
 * data cache
 * direct mapped, write-back and write-allocate, byte-masked writes,
 * dirty victims go back to memory before the refill
 */
`timescale 1ns/1ps

module dcache
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t req_i,
    output cpu_rsp_t rsp_o,
    output mem_req_t mem_req_o,
    input  mem_rsp_t mem_rsp_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_COMPARE,
        S_WRITE_BACK,
        S_READ_OUT,
        S_ALLOC,
        S_READ_IN,
        S_WRITE_IN,
        S_RETURN
    } state_e;

    state_e             state_q, state_d;
    cache_addr_u        req_addr, fill_addr, wb_addr;
    logic [INDEX_W-1:0] idx;
    logic [BANK_W-1:0]  bank_sel;
    logic               half;
    logic [NLINE-1:0]   valid_q;
    logic [NLINE-1:0]   dirty_q;
    logic [TAG_W-1:0]   tag_q [NLINE];
    logic               hit;
    logic               refill_done;
    logic               bank_we;
    logic [LINE_W-1:0]  bank_rd [NBANK];
    logic [LINE_W-1:0]  line_rd;
    logic [LINE_W-1:0]  merged;
    logic [LINE_W-1:0]  bank_wdata;
    logic [LINE_W-1:0]  wb_line_q;
    logic               ready_q;
    logic [WORD_W-1:0]  rdata_q;

    assign req_addr.raw = req_i.addr;
    assign idx          = req_addr.f.index;
    assign bank_sel     = idx[INDEX_W-1 -: BANK_W];
    assign half         = req_addr.f.offset[OFFSET_W-1];

    // refill goes to the request line, write-back to the stored tag
    always_comb begin
        fill_addr          = req_addr;
        fill_addr.f.offset = '0;
        wb_addr            = fill_addr;
        wb_addr.f.tag      = tag_q[idx];
    end

    assign hit         = valid_q[idx] && (tag_q[idx] == req_addr.f.tag);
    assign refill_done = (state_q == S_ALLOC) && mem_rsp_i.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req_i.valid) state_d = S_COMPARE;
            end
            S_COMPARE: begin
                if (hit) begin
                    state_d = S_READ_IN;
                end else if (valid_q[idx] && dirty_q[idx]) begin
                    state_d = S_READ_OUT;  // victim first
                end else begin
                    state_d = S_ALLOC;
                end
            end
            S_READ_OUT:   state_d = S_WRITE_BACK;
            S_WRITE_BACK: if (mem_rsp_i.ready) state_d = S_ALLOC;
            S_ALLOC:      if (mem_rsp_i.ready) state_d = S_COMPARE;
            S_READ_IN:    state_d = req_i.rw ? S_WRITE_IN : S_RETURN;
            S_WRITE_IN:   state_d = S_RETURN;
            S_RETURN:     state_d = S_IDLE;
            default:      state_d = S_IDLE;
        endcase
    end

    assign line_rd = bank_rd[bank_sel];

    // write bytes over the selected half of the line
    always_comb begin
        merged = line_rd;
        for (int i = 0; i < WORD_W/8; i++) begin
            if (req_i.wmask[i]) begin
                merged[half*WORD_W + i*8 +: 8] = req_i.wdata[i*8 +: 8];
            end
        end
    end

    assign bank_we    = refill_done || (state_q == S_WRITE_IN);
    assign bank_wdata = (state_q == S_WRITE_IN) ? merged : mem_rsp_i.rdata;

    for (genvar b = 0; b < NBANK; b++) begin : g_bank
        line_sram i_bank (
            .clk     (clk),
            .we_i    (bank_we && (bank_sel == BANK_W'(b))),
            .addr_i  (idx[LINE_AW-1:0]),
            .wdata_i (bank_wdata),
            .rdata_o (bank_rd[b])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (refill_done) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;
        end else if (state_q == S_WRITE_IN) begin
            dirty_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_q[idx] <= req_addr.f.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_READ_OUT) begin
            wb_line_q <= line_rd;  // victim line
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= (state_q == S_RETURN);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_RETURN) begin
            rdata_q <= line_rd[half*WORD_W +: WORD_W];
        end
    end

    assign rsp_o.ready = ready_q;
    assign rsp_o.rdata = rdata_q;

    assign mem_req_o.valid = (state_q == S_WRITE_BACK) || (state_q == S_ALLOC);
    assign mem_req_o.write = (state_q == S_WRITE_BACK);
    assign mem_req_o.addr  = mem_req_o.write ? wb_addr.raw : fill_addr.raw;
    assign mem_req_o.wdata = wb_line_q;

endmodule

//--- src/mem_arbiter.sv
/*
 * memory port arbiter
 * two fixed requesters, dcache first, grant held until memory ready
 */
`timescale 1ns/1ps

module mem_arbiter
    import cache_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t icache_req_i,
    input  mem_req_t dcache_req_i,
    output mem_rsp_t icache_rsp_o,
    output mem_rsp_t dcache_rsp_o,
    output mem_req_t mem_req_o,
    input  mem_rsp_t mem_rsp_i
);

    typedef enum logic [1:0] {
        G_IDLE,
        G_ICACHE,
        G_DCACHE
    } grant_e;

    grant_e grant_q, sel;

    // idle grants in the same cycle, otherwise the lock holds
    always_comb begin
        sel = grant_q;
        if (grant_q == G_IDLE) begin
            if (dcache_req_i.valid) begin
                sel = G_DCACHE;
            end else if (icache_req_i.valid) begin
                sel = G_ICACHE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= G_IDLE;
        end else if (mem_rsp_i.ready) begin
            grant_q <= G_IDLE;  // transfer done
        end else begin
            grant_q <= sel;
        end
    end

    always_comb begin
        mem_req_o    = '0;
        icache_rsp_o = '0;
        dcache_rsp_o = '0;
        case (sel)
            G_ICACHE: begin
                mem_req_o    = icache_req_i;
                icache_rsp_o = mem_rsp_i;
            end
            G_DCACHE: begin
                mem_req_o    = dcache_req_i;
                dcache_rsp_o = mem_rsp_i;
            end
            default: ;  // nothing forwarded
        endcase
    end

endmodule

//--- src/cache_subsys.sv
/*
 * L1 cache subsystem
 * instruction and data cache sharing one main-memory port
 */
`timescale 1ns/1ps

module cache_subsys
    import cache_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t icache_req_i,
    output cpu_rsp_t icache_rsp_o,
    input  cpu_req_t dcache_req_i,
    output cpu_rsp_t dcache_rsp_o,
    output mem_req_t mem_req_o,
    input  mem_rsp_t mem_rsp_i
);

    mem_req_t ic_mem_req, dc_mem_req;
    mem_rsp_t ic_mem_rsp, dc_mem_rsp;

    icache i_icache (
        .clk       (clk),
        .rst       (rst),
        .req_i     (icache_req_i),
        .rsp_o     (icache_rsp_o),
        .mem_req_o (ic_mem_req),
        .mem_rsp_i (ic_mem_rsp)
    );

    dcache i_dcache (
        .clk       (clk),
        .rst       (rst),
        .req_i     (dcache_req_i),
        .rsp_o     (dcache_rsp_o),
        .mem_req_o (dc_mem_req),
        .mem_rsp_i (dc_mem_rsp)
    );

    mem_arbiter i_arbiter (
        .clk          (clk),
        .rst          (rst),
        .icache_req_i (ic_mem_req),
        .dcache_req_i (dc_mem_req),
        .icache_rsp_o (ic_mem_rsp),
        .dcache_rsp_o (dc_mem_rsp),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i)
    );

endmodule

//--- verif/cache_subsys_assert.sv
/*
 * cache subsystem checks
 * ready pulses, memory valid hold, grant lock, quiet reset
 */
`timescale 1ns/1ps

module cache_subsys_assert
    import cache_bus_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input cpu_rsp_t icache_rsp_i,
    input cpu_rsp_t dcache_rsp_i,
    input mem_req_t mem_req_i,
    input mem_req_t ic_mem_req_i,
    input mem_req_t dc_mem_req_i,
    input mem_rsp_t ic_mem_rsp_i,
    input mem_rsp_t dc_mem_rsp_i
);

    int unsigned fail_cnt = 0;  // failed checks so far

    // port request matches a live cache request
    function automatic logic same_req(mem_req_t fwd, mem_req_t src);
        return src.valid && fwd.valid && fwd.write == src.write && fwd.addr == src.addr;
    endfunction

    ready_pulse: assert property (@(posedge clk) disable iff (rst)
        (icache_rsp_i.ready |=> !icache_rsp_i.ready) and
        (dcache_rsp_i.ready |=> !dcache_rsp_i.ready))
    else begin
        fail_cnt++;
        $error("cpu ready longer than one cycle");
    end

    // valid holds until the cache sees its own ready
    mem_valid_hold: assert property (@(posedge clk) disable iff (rst)
        (ic_mem_req_i.valid && !ic_mem_rsp_i.ready |=> ic_mem_req_i.valid) and
        (dc_mem_req_i.valid && !dc_mem_rsp_i.ready |=> dc_mem_req_i.valid))
    else begin
        fail_cnt++;
        $error("memory valid dropped before ready");
    end

    // a forwarded request keeps the port until its own ready
    grant_locked: assert property (@(posedge clk) disable iff (rst)
        (same_req(mem_req_i, ic_mem_req_i) && !ic_mem_rsp_i.ready
            |=> same_req(mem_req_i, ic_mem_req_i)) and
        (same_req(mem_req_i, dc_mem_req_i) && !dc_mem_rsp_i.ready
            |=> same_req(mem_req_i, dc_mem_req_i)))
    else begin
        fail_cnt++;
        $error("arbiter forwarded a request that was not granted");
    end

    quiet_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !icache_rsp_i.ready && !dcache_rsp_i.ready)
    else begin
        fail_cnt++;
        $error("ready pulse during reset");
    end

endmodule

bind cache_subsys cache_subsys_assert i_assert (
    .clk          (clk),
    .rst          (rst),
    .icache_rsp_i (icache_rsp_o),
    .dcache_rsp_i (dcache_rsp_o),
    .mem_req_i    (mem_req_o),
    .ic_mem_req_i (ic_mem_req),
    .dc_mem_req_i (dc_mem_req),
    .ic_mem_rsp_i (ic_mem_rsp),
    .dc_mem_rsp_i (dc_mem_rsp)
);

//--- verif/cache_subsys_tb.sv
/*
 * L1 cache subsystem testbench
 * main-memory model with random delay, tests read from a data file
 */
`timescale 1ns/1ps

module cache_subsys_tb
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
();

    localparam int TIMEOUT_CYC = 300;

    logic     clk = 1'b0;
    logic     rst;
    cpu_req_t ic_req;
    cpu_req_t dc_req;
    cpu_rsp_t ic_rsp;
    cpu_rsp_t dc_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp = '0;

    logic [LINE_W-1:0] mem_lines [logic [ADDR_W-1:0]];  // keyed by line address
    logic [31:0]       rng_state = 32'h4132_509f;
    logic              mem_busy  = 1'b0;
    int                mem_wait  = 0;

    cache_subsys i_dut (
        .clk          (clk),
        .rst          (rst),
        .icache_req_i (ic_req),
        .icache_rsp_o (ic_rsp),
        .dcache_req_i (dc_req),
        .dcache_rsp_o (dc_rsp),
        .mem_req_o    (mem_req),
        .mem_rsp_i    (mem_rsp)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // untouched memory holds the inverse of each word's byte address
    function automatic logic [LINE_W-1:0] fresh_line(logic [ADDR_W-1:0] line_addr);
        return {~(line_addr + 64'd8), ~line_addr};
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic serve_mem();
        logic [ADDR_W-1:0] la;
        la = mem_req.addr;
        assert (la[OFFSET_W-1:0] == '0) else begin
            report_failure($sformatf("memory request address %h is not line aligned", la));
        end
        if (!mem_lines.exists(la)) begin
            mem_lines[la] = fresh_line(la);
        end
        if (mem_req.write) begin
            mem_lines[la] = mem_req.wdata;  // write-back
        end
        mem_rsp.rdata = mem_lines[la];
        mem_rsp.ready = 1'b1;
        mem_busy      = 1'b0;
    endtask

    // ready 1 to 4 cycles after valid
    always @(negedge clk) begin
        if (rst) begin
            mem_rsp  = '0;
            mem_busy = 1'b0;
        end else if (mem_rsp.ready) begin
            mem_rsp.ready = 1'b0;  // one-cycle pulse
        end else if (mem_req.valid) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = 1 + int'(xorshift32() % 32'd4);
            end
            mem_wait--;
            if (mem_wait == 0) begin
                serve_mem();
            end
        end
    end

    task automatic run_test(
        input string       name,
        input logic        ic_on,
        input logic [63:0] ic_addr,
        input logic [63:0] ic_exp,
        input logic        dc_on,
        input logic        dc_rw,
        input logic [63:0] dc_addr,
        input logic [63:0] dc_wdata,
        input logic [7:0]  dc_wmask,
        input logic [63:0] dc_exp
    );
        logic ic_done;
        logic dc_done;
        int   cycles;
        ic_req       = '0;
        ic_req.valid = ic_on;
        ic_req.addr  = ic_addr;
        dc_req       = '0;
        dc_req.valid = dc_on;
        dc_req.rw    = dc_rw;
        dc_req.addr  = dc_addr;
        dc_req.wdata = dc_wdata;
        dc_req.wmask = dc_wmask;
        ic_done      = !ic_on;
        dc_done      = !dc_on;
        cycles       = 0;
        while (!(ic_done && dc_done)) begin
            @(negedge clk);
            cycles++;
            if (!ic_done && ic_rsp.ready) begin
                ic_done      = 1'b1;
                ic_req.valid = 1'b0;
                assert (ic_rsp.rdata == ic_exp) else begin
                    report_failure($sformatf("Mismatch in %s icache: expected %h actual %h",
                                             name, ic_exp, ic_rsp.rdata));
                end
            end
            if (!dc_done && dc_rsp.ready) begin
                dc_done      = 1'b1;
                dc_req.valid = 1'b0;
                assert (dc_rw || dc_rsp.rdata == dc_exp) else begin  // no data on writes
                    report_failure($sformatf("Mismatch in %s dcache: expected %h actual %h",
                                             name, dc_exp, dc_rsp.rdata));
                end
            end
            if (cycles > TIMEOUT_CYC) begin
                report_failure($sformatf("timeout in %s: %s ready never came", name,
                                         ic_done ? "dcache" : "icache"));
            end
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        int          ntests;
        string       text;
        string       name;
        logic [63:0] ic_en, ic_addr, ic_exp;
        logic [63:0] dc_en, dc_rw, dc_addr, dc_wdata, dc_wmask, dc_exp;
        ic_req = '0;
        dc_req = '0;
        rst    = 1'b1;
        ntests = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        fd = $fopen("verif/cache_tests.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open verif/cache_tests.txt");
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() > 1 && text.getc(0) != "#") begin
                fields = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h", name,
                                 ic_en, ic_addr, ic_exp, dc_en, dc_rw,
                                 dc_addr, dc_wdata, dc_wmask, dc_exp);
                if (fields != 10) begin
                    report_failure({"malformed test line: ", text});
                end
                run_test(name, ic_en[0], ic_addr, ic_exp, dc_en[0], dc_rw[0],
                         dc_addr, dc_wdata, dc_wmask[7:0], dc_exp);
                ntests++;
                repeat (xorshift32() % 32'd4) @(negedge clk);  // idle gap
            end
        end
        $fclose(fd);
        if (ntests == 0) begin
            report_failure("no tests found in verif/cache_tests.txt");
        end
        if (i_dut.i_assert.fail_cnt != 0) begin
            report_failure("a concurrent assertion on the DUT failed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- verif/cache_tests.txt
# name ic_en ic_addr ic_expected dc_en dc_rw dc_addr dc_wdata dc_wmask dc_expected
# all numbers hex, dc_expected is not checked on writes
ic_miss          1 10000 fffffffffffeffff 0 0 0 0 0 0
ic_hit_hi        1 10008 fffffffffffefff7 0 0 0 0 0 0
ic_hit_lo        1 10000 fffffffffffeffff 0 0 0 0 0 0
dc_miss_b0       0 0 0 1 0 80000010 0 0 ffffffff7fffffef
dc_miss_b1       0 0 0 1 0 80000418 0 0 ffffffff7ffffbe7
dc_miss_b2       0 0 0 1 0 80000820 0 0 ffffffff7ffff7df
dc_miss_b3       0 0 0 1 0 80000c38 0 0 ffffffff7ffff3c7
dc_wr_hit_lo     0 0 0 1 1 80000010 1122334455667788 0f 0
dc_rd_merge_lo   0 0 0 1 0 80000010 0 0 ffffffff55667788
dc_wr_hit_ends   0 0 0 1 1 80000010 aabbccddeeff0011 81 0
dc_rd_merge_ends 0 0 0 1 0 80000010 0 0 aaffffff55667711
dc_evict_a       0 0 0 1 0 80001010 0 0 ffffffff7fffefef
dc_reload_a      0 0 0 1 0 80000010 0 0 aaffffff55667711
dc_reload_a_hi   0 0 0 1 0 80000018 0 0 ffffffff7fffffe7
both_miss        1 10410 fffffffffffefbef 1 0 80002020 0 0 ffffffff7fffdfdf
ic_miss_dc_hit   1 10800 fffffffffffef7ff 1 0 80000c30 0 0 ffffffff7ffff3cf
dc_wr_alloc      0 0 0 1 1 80003048 0123456789abcdef 3c 0
dc_rd_alloc      0 0 0 1 0 80003048 0 0 ffff456789abcfb7
dc_rd_alloc_lo   0 0 0 1 0 80003040 0 0 ffffffff7fffcfbf
dc_evict_b       0 0 0 1 0 80004040 0 0 ffffffff7fffbfbf
dc_reload_b      0 0 0 1 0 80003048 0 0 ffff456789abcfb7
dc_wr_hit_hi     0 0 0 1 1 80003040 0 f0 0
both_miss_wb     1 10c00 fffffffffffef3ff 1 0 80004048 0 0 ffffffff7fffbfb7
dc_reload_c      0 0 0 1 0 80003040 0 0 000000007fffcfbf

//--- sources.f
src/cache_geom_pkg.sv
src/cache_bus_pkg.sv
src/line_sram.sv
src/icache.sv
src/dcache.sv
src/mem_arbiter.sv
src/cache_subsys.sv
verif/cache_subsys_assert.sv
verif/cache_subsys_tb.sv

//--- Makefile
# Verilator build and run of the L1 cache subsystem testbench

VERILATOR ?= verilator
TOP       ?= cache_subsys_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
